// File: Bender.yml
package:
  name: scheduler

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/SchedulerTypes.sv
      - verilog/Picker.sv
      - verilog/SelectLogic.sv
      - verilog/WakeupLogic.sv
      - verilog/IssueQueue.sv
      - verilog/Scheduler.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - sim/ClockGen.sv
      - sim/SchedulerTb.sv

// File: all.f
+incdir+verilog
verilog/SchedulerTypes.sv
verilog/Picker.sv
verilog/SelectLogic.sv
verilog/WakeupLogic.sv
verilog/IssueQueue.sv
verilog/Scheduler.sv
sim/ClockGen.sv
sim/SchedulerTb.sv

// File: sim/ClockGen.sv
//**************************************************
// Testbench clock (8 ns period) and synchronous
// reset held for the first cycles
//**************************************************

module ClockGen #(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule : ClockGen

// File: sim/SchedulerTb.sv
//**************************************************
// Scheduler testbench: directed and random stimulus,
// cycle model of the queue, slot checks, watchdog
//**************************************************

`include "scheduler_cfg.svh"

module SchedulerTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS = 8;
    localparam int DIRECTED_CYCLES = 80;
    localparam int RANDOM_CYCLES = 60;
    localparam int DRAIN_CYCLES = 32 + 10;
    localparam int TEST_CYCLES = 5 + DIRECTED_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
    localparam int MARGIN_CYCLES = 100;

    logic clk;
    logic reset;
    logic flush;
    logic dispatchValid;
    SchedulerTypes::DispatchOp dispatchOp;
    SchedulerTypes::WakeupTag extWakeup;
    SchedulerTypes::IssueSlot issueSlots [`SCHED_ISSUE_WIDTH];
    logic dispatchFull;

    SchedulerTypes::QueueEntry modelEntry [`SCHED_ENTRY_NUM];
    SchedulerTypes::IssueSlot modelSlot [`SCHED_ISSUE_WIDTH];
    logic modelFull;
    logic [255:0] issuedMask = '0;
    logic [`SCHED_OPID_WIDTH-1:0] nextId = '0;
    int seed = 32'ha120;
    int errorCount = 0;

    ClockGen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(5)) clockGen (.clk(clk), .reset(reset));

    Scheduler u_dut (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .dispatchValid(dispatchValid),
        .dispatchOp(dispatchOp),
        .extWakeup(extWakeup),
        .issueSlots(issueSlots),
        .dispatchFull(dispatchFull)
    );

    // Tag seen on the external bus or on an issued slot with a destination
    function automatic logic woken(input logic [`SCHED_TAG_WIDTH-1:0] tag);
        logic hit;

        hit = extWakeup.valid && extWakeup.tag == tag;
        for (int s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin
            if (modelSlot[s].valid && modelSlot[s].hasDest && modelSlot[s].destTag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Reference queue, one step per clock edge
    always @(posedge clk) begin : modelStep
        SchedulerTypes::QueueEntry nextEntry [`SCHED_ENTRY_NUM];
        SchedulerTypes::IssueSlot nextSlot [`SCHED_ISSUE_WIDTH];
        int intCount;
        int freeIdx;
        int slot;

        nextEntry = modelEntry;
        intCount = 0;
        freeIdx = -1;
        for (int s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin
            nextSlot[s] = '0;
        end
        if (reset || flush) begin
            for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
                nextEntry[i].valid = 1'b0;
            end
        end else begin
            for (int i = `SCHED_ENTRY_NUM - 1; i >= 0; i--) begin
                if (!modelEntry[i].valid) freeIdx = i;
            end
            for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
                slot = -1;
                nextEntry[i].op.srcReady0 = modelEntry[i].op.srcReady0 ||
                                            woken(modelEntry[i].op.srcTag0);
                nextEntry[i].op.srcReady1 = modelEntry[i].op.srcReady1 ||
                                            woken(modelEntry[i].op.srcTag1);
                if (modelEntry[i].valid && nextEntry[i].op.srcReady0 &&
                        nextEntry[i].op.srcReady1) begin
                    case (modelEntry[i].op.pipe)
                        SchedulerTypes::PIPE_INT: begin
                            if (intCount < `SCHED_INT_WIDTH) begin
                                slot = intCount;
                                intCount++;
                            end
                        end
                        SchedulerTypes::PIPE_COMPLEX: begin
                            if (!nextSlot[`SCHED_COMPLEX_SLOT].valid) slot = `SCHED_COMPLEX_SLOT;
                        end
                        default: begin
                            if (!nextSlot[`SCHED_MEM_SLOT].valid) slot = `SCHED_MEM_SLOT;
                        end
                    endcase
                end
                if (slot >= 0) begin
                    nextSlot[slot] = '{valid: 1'b1, opId: modelEntry[i].op.opId,
                                       hasDest: modelEntry[i].op.hasDest,
                                       destTag: modelEntry[i].op.destTag,
                                       entryPtr: SchedulerTypes::EntryPtr'(i)};
                    nextEntry[i].valid = 1'b0;
                end
            end
            if (dispatchValid && freeIdx >= 0) begin
                nextEntry[freeIdx].valid = 1'b1;
                nextEntry[freeIdx].op = dispatchOp;
                nextEntry[freeIdx].op.srcReady0 = dispatchOp.srcReady0 || woken(dispatchOp.srcTag0);
                nextEntry[freeIdx].op.srcReady1 = dispatchOp.srcReady1 || woken(dispatchOp.srcTag1);
            end
        end
        modelEntry <= nextEntry;
        modelSlot <= nextSlot;
    end

    always_comb begin
        modelFull = 1'b1;
        for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
            if (!modelEntry[i].valid) modelFull = 1'b0;
        end
    end

    always @(posedge clk) begin
        for (int s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin
            if (issueSlots[s].valid) issuedMask[issueSlots[s].opId] <= 1'b1;
        end
    end

    FullMatch: assert property (@(posedge clk) disable iff (reset) dispatchFull == modelFull)
        else begin
            errorCount++;
            $display("ERROR %0t dispatchFull dut=%b model=%b", $time,
                     $sampled(dispatchFull), $sampled(modelFull));
        end

    for (genvar s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin : gSlotCheck
        SlotValid: assert property (@(posedge clk) disable iff (reset)
            issueSlots[s].valid == modelSlot[s].valid)
            else begin
                errorCount++;
                $display("ERROR %0t issueSlots[%0d].valid dut=%b model=%b", $time, s,
                         $sampled(issueSlots[s].valid), $sampled(modelSlot[s].valid));
            end
        SlotOpId: assert property (@(posedge clk) disable iff (reset)
            modelSlot[s].valid |-> issueSlots[s].opId == modelSlot[s].opId)
            else begin
                errorCount++;
                $display("ERROR %0t issueSlots[%0d].opId dut=%0d model=%0d", $time, s,
                         $sampled(issueSlots[s].opId), $sampled(modelSlot[s].opId));
            end
        SlotPayload: assert property (@(posedge clk) disable iff (reset)
            modelSlot[s].valid |-> issueSlots[s].hasDest == modelSlot[s].hasDest &&
                issueSlots[s].destTag == modelSlot[s].destTag &&
                issueSlots[s].entryPtr == modelSlot[s].entryPtr)
            else begin
                errorCount++;
                $display("ERROR %0t issueSlots[%0d] dut=%h model=%h", $time, s,
                         $sampled(issueSlots[s]), $sampled(modelSlot[s]));
            end
        IssueOnce: assert property (@(posedge clk) disable iff (reset)
            issueSlots[s].valid |-> !issuedMask[issueSlots[s].opId])
            else begin
                errorCount++;
                $display("Slot %0d issued op %0d a second time at %0t", s,
                         $sampled(issueSlots[s].opId), $time);
            end
    end

    task automatic clearInputs();
        dispatchValid = 1'b0;
        extWakeup = '0;
        flush = 1'b0;
    endtask

    task automatic driveOp(input SchedulerTypes::PipeClass pipe,
                           input logic [`SCHED_TAG_WIDTH-1:0] dest,
                           input logic [`SCHED_TAG_WIDTH-1:0] src0, input logic rdy0,
                           input logic [`SCHED_TAG_WIDTH-1:0] src1, input logic rdy1);
        dispatchValid = 1'b1;
        dispatchOp = '{opId: nextId, pipe: pipe, hasDest: 1'b1, destTag: dest,
                       srcTag0: src0, srcTag1: src1, srcReady0: rdy0, srcReady1: rdy1};
        nextId++;
    endtask

    task automatic sendOp(input SchedulerTypes::PipeClass pipe,
                          input logic [`SCHED_TAG_WIDTH-1:0] dest,
                          input logic [`SCHED_TAG_WIDTH-1:0] src0, input logic rdy0,
                          input logic [`SCHED_TAG_WIDTH-1:0] src1, input logic rdy1);
        @(negedge clk);
        clearInputs();
        driveOp(pipe, dest, src0, rdy0, src1, rdy1);
    endtask

    task automatic pulseWakeup(input logic [`SCHED_TAG_WIDTH-1:0] tag);
        @(negedge clk);
        clearInputs();
        extWakeup = '{valid: 1'b1, tag: tag};
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            clearInputs();
        end
    endtask

    task automatic randomTraffic(input int cycles);
        int r;

        repeat (cycles) begin
            @(negedge clk);
            clearInputs();
            r = $random(seed);
            if (r[0] && !dispatchFull) begin
                driveOp(SchedulerTypes::PipeClass'($unsigned(r[15:8]) % 3), r[20:16],
                        r[25:21], r[1], r[30:26], r[2]);
            end else if (r[3]) begin
                extWakeup = '{valid: 1'b1, tag: r[8:4]};
            end
        end
    endtask

    initial begin
        clearInputs();
        dispatchOp = '0;
        wait (!reset);

        // Ready op straight to its slot
        sendOp(SchedulerTypes::PIPE_INT, 5'd1, 5'd0, 1'b1, 5'd0, 1'b1);
        idle(4);

        // Five ops on one tag, released together
        sendOp(SchedulerTypes::PIPE_INT, 5'd2, 5'd10, 1'b0, 5'd0, 1'b1);
        sendOp(SchedulerTypes::PIPE_INT, 5'd3, 5'd10, 1'b0, 5'd0, 1'b1);
        sendOp(SchedulerTypes::PIPE_INT, 5'd4, 5'd0, 1'b1, 5'd10, 1'b0);
        sendOp(SchedulerTypes::PIPE_COMPLEX, 5'd5, 5'd10, 1'b0, 5'd0, 1'b1);
        sendOp(SchedulerTypes::PIPE_MEM, 5'd6, 5'd10, 1'b0, 5'd10, 1'b0);
        // Issued op without a destination carries their tag
        sendOp(SchedulerTypes::PIPE_INT, 5'd10, 5'd0, 1'b1, 5'd0, 1'b1);
        dispatchOp.hasDest = 1'b0;
        idle(2);
        pulseWakeup(5'd10);
        idle(4);

        // Producer, one waiting dependent, one dispatched during the broadcast
        sendOp(SchedulerTypes::PIPE_INT, 5'd12, 5'd0, 1'b1, 5'd0, 1'b1);
        sendOp(SchedulerTypes::PIPE_COMPLEX, 5'd13, 5'd12, 1'b0, 5'd0, 1'b1);
        sendOp(SchedulerTypes::PIPE_MEM, 5'd14, 5'd0, 1'b1, 5'd12, 1'b0);
        idle(5);

        // Fill the queue, then wake both tags
        for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
            sendOp(SchedulerTypes::PipeClass'(i % 3), 5'd0, 5'd20, 1'b0, 5'd21, 1'b0);
        end
        idle(2);
        pulseWakeup(5'd20);
        pulseWakeup(5'd21);
        idle(8);

        // Flush while the memory op is selected and another op dispatches
        for (int i = 0; i < 3; i++) begin
            sendOp(SchedulerTypes::PipeClass'(i), 5'd0, 5'd25, i == 2, 5'd0, 1'b1);
        end
        @(negedge clk);
        clearInputs();
        driveOp(SchedulerTypes::PIPE_INT, 5'd0, 5'd0, 1'b1, 5'd0, 1'b1);
        flush = 1'b1;
        pulseWakeup(5'd25);
        idle(4);

        randomTraffic(RANDOM_CYCLES);
        for (int t = 0; t < 32; t++) begin
            pulseWakeup(t[`SCHED_TAG_WIDTH-1:0]);
        end
        idle(8);

        $display("Scheduler checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * PERIOD_NS);
        $display("Watchdog expired before the stimulus finished, %0d errors", errorCount);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : SchedulerTb

// File: verilog/IssueQueue.sv
//**************************************************
// Issue queue: entry storage, lowest-free
// allocation, release on grant, issue register
//**************************************************

`include "scheduler_cfg.svh"

module IssueQueue (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic dispatchValid,
    input  SchedulerTypes::DispatchOp dispatchOp,
    input  logic [1:0] dispatchReady,
    input  logic [1:0] srcReadyNext [`SCHED_ENTRY_NUM],
    input  logic [`SCHED_ISSUE_WIDTH-1:0] selected,
    input  SchedulerTypes::EntryPtr selectedPtr [`SCHED_ISSUE_WIDTH],
    input  SchedulerTypes::EntryVector selectedVector [`SCHED_ISSUE_WIDTH],
    output SchedulerTypes::QueueEntry entries [`SCHED_ENTRY_NUM],
    output logic dispatchFull,
    output SchedulerTypes::IssueSlot issueSlots [`SCHED_ISSUE_WIDTH]
);

    SchedulerTypes::EntryVector entryValid;
    SchedulerTypes::DispatchOp entryOp [`SCHED_ENTRY_NUM];
    SchedulerTypes::IssueSlot slotReg [`SCHED_ISSUE_WIDTH];

    SchedulerTypes::EntryPtr allocPtr;
    logic allocFound;
    logic dispatchAccept;
    SchedulerTypes::EntryVector releaseVector;

    // Lowest free entry wins
    always_comb begin
        allocFound = 1'b0;
        allocPtr = '0;
        for (int i = `SCHED_ENTRY_NUM - 1; i >= 0; i--) begin
            if (!entryValid[i]) begin
                allocFound = 1'b1;
                allocPtr = SchedulerTypes::EntryPtr'(i);
            end
        end
    end

    assign dispatchFull = !allocFound;
    assign dispatchAccept = dispatchValid && allocFound && !flush;

    always_comb begin
        releaseVector = '0;
        for (int s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin
            releaseVector = releaseVector | selectedVector[s];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            entryValid <= '0;
        end else begin
            for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
                if (dispatchAccept && allocPtr == i) begin
                    entryValid[i] <= 1'b1;
                end else if (releaseVector[i]) begin
                    entryValid[i] <= 1'b0;
                end
            end
        end
    end

    // Payload and ready bits, meaningful only while the entry is valid
    always_ff @(posedge clk) begin
        for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
            if (dispatchAccept && allocPtr == i) begin
                entryOp[i] <= dispatchOp;
                entryOp[i].srcReady0 <= dispatchReady[0];
                entryOp[i].srcReady1 <= dispatchReady[1];
            end else begin
                entryOp[i].srcReady0 <= srcReadyNext[i][0];
                entryOp[i].srcReady1 <= srcReadyNext[i][1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
            entries[i].valid = entryValid[i];
            entries[i].op = entryOp[i];
        end
    end

    // Issue register, one stage after select
    always_ff @(posedge clk) begin
        for (int s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin
            if (reset || flush) begin
                slotReg[s].valid <= 1'b0;
            end else begin
                slotReg[s].valid <= selected[s];
            end
            slotReg[s].opId <= entryOp[selectedPtr[s]].opId;
            slotReg[s].hasDest <= entryOp[selectedPtr[s]].hasDest;
            slotReg[s].destTag <= entryOp[selectedPtr[s]].destTag;
            slotReg[s].entryPtr <= selectedPtr[s];
        end
    end

    assign issueSlots = slotReg;

    DispatchWhileFull: assert property (
        @(posedge clk) disable iff (reset)
        !(dispatchValid && dispatchFull)
    ) else $error("Dispatch while issue queue is full");

    for (genvar s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin : gSlotCheck
        // Select only ever names a held entry
        SelectedEntryHeld: assert property (
            @(posedge clk) disable iff (reset)
            selected[s] |-> entryValid[selectedPtr[s]]
        ) else $error("Slot %0d selected free entry %0d", s, selectedPtr[s]);
    end

endmodule : IssueQueue

// File: verilog/Picker.sv
//**************************************************
// Picker: grants up to GRANT_NUM requesters,
// lowest index first
//**************************************************

module Picker #(
    parameter int ENTRY_NUM = 8,
    parameter int GRANT_NUM = 2
) (
    input  logic [ENTRY_NUM-1:0] req,
    output logic [ENTRY_NUM-1:0] grant,
    output logic [$clog2(ENTRY_NUM)-1:0] grantPtr [GRANT_NUM],
    output logic [GRANT_NUM-1:0] granted
);

    localparam int PTR_WIDTH = $clog2(ENTRY_NUM);

    // Grant k goes to the (k+1)-th set request
    always_comb begin
        int count;

        count = 0;
        grant = '0;
        granted = '0;
        for (int k = 0; k < GRANT_NUM; k++) begin
            grantPtr[k] = '0;
        end

        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (req[i] && count < GRANT_NUM) begin
                grant[i] = 1'b1;
                granted[count] = 1'b1;
                grantPtr[count] = PTR_WIDTH'(i);
                count++;
            end
        end
    end

    // Grants stay inside the request set and within the pipe width
    GrantWithinRequest: assert #0 (
        ((grant & ~req) == '0) && ($countones(grant) <= GRANT_NUM)
    ) else $error("Picker grant %b exceeds request %b or width %0d", grant, req, GRANT_NUM);

endmodule : Picker

// File: verilog/Scheduler.sv
//**************************************************
// Scheduler top: issue queue, wakeup, select and
// the broadcast of issued destination tags
//**************************************************

`include "scheduler_cfg.svh"

module Scheduler (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic dispatchValid,
    input  SchedulerTypes::DispatchOp dispatchOp,
    input  SchedulerTypes::WakeupTag extWakeup,
    output SchedulerTypes::IssueSlot issueSlots [`SCHED_ISSUE_WIDTH],
    output logic dispatchFull
);

    SchedulerTypes::QueueEntry entries [`SCHED_ENTRY_NUM];
    logic [1:0] srcReadyNext [`SCHED_ENTRY_NUM];
    logic [1:0] dispatchReady;
    SchedulerTypes::EntryVector ready;

    logic [`SCHED_ISSUE_WIDTH-1:0] selected;
    SchedulerTypes::EntryPtr selectedPtr [`SCHED_ISSUE_WIDTH];
    SchedulerTypes::EntryVector selectedVector [`SCHED_ISSUE_WIDTH];

    SchedulerTypes::WakeupTag issueWakeup [`SCHED_ISSUE_WIDTH];

    // Issued ops with a destination wake their dependents
    always_comb begin
        for (int s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin
            issueWakeup[s].valid = issueSlots[s].valid && issueSlots[s].hasDest;
            issueWakeup[s].tag = issueSlots[s].destTag;
        end
    end

    IssueQueue issueQueue (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .dispatchValid(dispatchValid),
        .dispatchOp(dispatchOp),
        .dispatchReady(dispatchReady),
        .srcReadyNext(srcReadyNext),
        .selected(selected),
        .selectedPtr(selectedPtr),
        .selectedVector(selectedVector),
        .entries(entries),
        .dispatchFull(dispatchFull),
        .issueSlots(issueSlots)
    );

    WakeupLogic wakeupLogic (
        .entries(entries),
        .dispatchValid(dispatchValid),
        .dispatchOp(dispatchOp),
        .extWakeup(extWakeup),
        .issueWakeup(issueWakeup),
        .srcReadyNext(srcReadyNext),
        .dispatchReady(dispatchReady),
        .ready(ready)
    );

    SelectLogic selectLogic (
        .clk(clk),
        .reset(reset),
        .entries(entries),
        .ready(ready),
        .selected(selected),
        .selectedPtr(selectedPtr),
        .selectedVector(selectedVector)
    );

endmodule : Scheduler

// File: verilog/SchedulerTypes.sv
//**************************************************
// Scheduler types: pipe class, entry index/vector,
// dispatched op, queue entry, issue slot, wakeup tag
//**************************************************

`include "scheduler_cfg.svh"

package SchedulerTypes;

    typedef enum logic [1:0] {
        PIPE_INT,
        PIPE_COMPLEX,
        PIPE_MEM
    } PipeClass;

    typedef logic [`SCHED_ENTRY_PTR_WIDTH-1:0] EntryPtr;
    typedef logic [`SCHED_ENTRY_NUM-1:0] EntryVector;

    // Renamed op as it arrives from dispatch
    typedef struct packed {
        logic [`SCHED_OPID_WIDTH-1:0] opId;
        PipeClass pipe;
        logic hasDest;
        logic [`SCHED_TAG_WIDTH-1:0] destTag;
        logic [`SCHED_TAG_WIDTH-1:0] srcTag0;
        logic [`SCHED_TAG_WIDTH-1:0] srcTag1;
        logic srcReady0;
        logic srcReady1;
    } DispatchOp;

    typedef struct packed {
        logic valid;
        DispatchOp op;
    } QueueEntry;

    // One registered issue slot, also the source of the issue broadcast
    typedef struct packed {
        logic valid;
        logic [`SCHED_OPID_WIDTH-1:0] opId;
        logic hasDest;
        logic [`SCHED_TAG_WIDTH-1:0] destTag;
        EntryPtr entryPtr;
    } IssueSlot;

    typedef struct packed {
        logic valid;
        logic [`SCHED_TAG_WIDTH-1:0] tag;
    } WakeupTag;

endpackage : SchedulerTypes

// File: verilog/SelectLogic.sv
//**************************************************
// Select logic: per-class requests from ready
// entries, three pickers, grants onto issue slots
//**************************************************

`include "scheduler_cfg.svh"

module SelectLogic (
    input  logic clk,
    input  logic reset,
    input  SchedulerTypes::QueueEntry entries [`SCHED_ENTRY_NUM],
    input  SchedulerTypes::EntryVector ready,
    output logic [`SCHED_ISSUE_WIDTH-1:0] selected,
    output SchedulerTypes::EntryPtr selectedPtr [`SCHED_ISSUE_WIDTH],
    output SchedulerTypes::EntryVector selectedVector [`SCHED_ISSUE_WIDTH]
);

    SchedulerTypes::EntryVector intRequest;
    SchedulerTypes::EntryVector compRequest;
    SchedulerTypes::EntryVector memRequest;

    SchedulerTypes::EntryVector intGrant;
    SchedulerTypes::EntryVector compGrant;
    SchedulerTypes::EntryVector memGrant;

    logic [`SCHED_INT_WIDTH-1:0] intSelected;
    logic [`SCHED_COMPLEX_WIDTH-1:0] compSelected;
    logic [`SCHED_MEM_WIDTH-1:0] memSelected;

    SchedulerTypes::EntryPtr intSelectedPtr [`SCHED_INT_WIDTH];
    SchedulerTypes::EntryPtr compSelectedPtr [`SCHED_COMPLEX_WIDTH];
    SchedulerTypes::EntryPtr memSelectedPtr [`SCHED_MEM_WIDTH];

    SchedulerTypes::EntryVector slotUnion;
    logic slotOverlap;

    always_comb begin
        for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
            intRequest[i] = entries[i].valid && ready[i] &&
                            entries[i].op.pipe == SchedulerTypes::PIPE_INT;
            compRequest[i] = entries[i].valid && ready[i] &&
                             entries[i].op.pipe == SchedulerTypes::PIPE_COMPLEX;
            memRequest[i] = entries[i].valid && ready[i] &&
                            entries[i].op.pipe == SchedulerTypes::PIPE_MEM;
        end
    end

    Picker #(
        .ENTRY_NUM(`SCHED_ENTRY_NUM),
        .GRANT_NUM(`SCHED_INT_WIDTH)
    ) intPicker (
        .req(intRequest),
        .grant(intGrant),
        .grantPtr(intSelectedPtr),
        .granted(intSelected)
    );

    Picker #(
        .ENTRY_NUM(`SCHED_ENTRY_NUM),
        .GRANT_NUM(`SCHED_COMPLEX_WIDTH)
    ) compPicker (
        .req(compRequest),
        .grant(compGrant),
        .grantPtr(compSelectedPtr),
        .granted(compSelected)
    );

    Picker #(
        .ENTRY_NUM(`SCHED_ENTRY_NUM),
        .GRANT_NUM(`SCHED_MEM_WIDTH)
    ) memPicker (
        .req(memRequest),
        .grant(memGrant),
        .grantPtr(memSelectedPtr),
        .granted(memSelected)
    );

    // Fixed slot order: integer, complex, memory
    always_comb begin
        for (int i = 0; i < `SCHED_INT_WIDTH; i++) begin
            selected[i] = intSelected[i];
            selectedPtr[i] = intSelectedPtr[i];
        end
        for (int i = 0; i < `SCHED_COMPLEX_WIDTH; i++) begin
            selected[`SCHED_COMPLEX_SLOT + i] = compSelected[i];
            selectedPtr[`SCHED_COMPLEX_SLOT + i] = compSelectedPtr[i];
        end
        for (int i = 0; i < `SCHED_MEM_WIDTH; i++) begin
            selected[`SCHED_MEM_SLOT + i] = memSelected[i];
            selectedPtr[`SCHED_MEM_SLOT + i] = memSelectedPtr[i];
        end

        // One-hot entry vector per slot
        for (int s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin
            if (selected[s]) begin
                selectedVector[s] = SchedulerTypes::EntryVector'(1) << selectedPtr[s];
            end else begin
                selectedVector[s] = '0;
            end
        end
    end

    always_comb begin
        slotUnion = '0;
        slotOverlap = 1'b0;
        for (int s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin
            slotOverlap = slotOverlap || ((slotUnion & selectedVector[s]) != '0);
            slotUnion = slotUnion | selectedVector[s];
        end
    end

    // No entry on two slots, and the slots carry exactly the picker grants
    SlotsDistinct: assert property (
        @(posedge clk) disable iff (reset)
        !slotOverlap && slotUnion == (intGrant | compGrant | memGrant)
    ) else $error("Select slots overlap or differ from grants: %b", slotUnion);

endmodule : SelectLogic

// File: verilog/WakeupLogic.sv
//**************************************************
// Wakeup logic: tag match of broadcasts against
// waiting sources, per-entry readiness
//**************************************************

`include "scheduler_cfg.svh"

module WakeupLogic (
    input  SchedulerTypes::QueueEntry entries [`SCHED_ENTRY_NUM],
    input  logic dispatchValid,
    input  SchedulerTypes::DispatchOp dispatchOp,
    input  SchedulerTypes::WakeupTag extWakeup,
    input  SchedulerTypes::WakeupTag issueWakeup [`SCHED_ISSUE_WIDTH],
    output logic [1:0] srcReadyNext [`SCHED_ENTRY_NUM],
    output logic [1:0] dispatchReady,
    output SchedulerTypes::EntryVector ready
);

    // External broadcast first, then one per issue slot
    localparam int BCAST_NUM = `SCHED_ISSUE_WIDTH + 1;

    SchedulerTypes::WakeupTag broadcast [BCAST_NUM];

    function automatic logic tagMatch(
        input logic [`SCHED_TAG_WIDTH-1:0] tag,
        input SchedulerTypes::WakeupTag bus [BCAST_NUM]
    );
        logic hit;

        hit = 1'b0;
        for (int b = 0; b < BCAST_NUM; b++) begin
            if (bus[b].valid && bus[b].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        broadcast[0] = extWakeup;
        for (int s = 0; s < `SCHED_ISSUE_WIDTH; s++) begin
            broadcast[s + 1] = issueWakeup[s];
        end
    end

    // Held ready bits ORed with this cycle's matches
    always_comb begin
        for (int i = 0; i < `SCHED_ENTRY_NUM; i++) begin
            srcReadyNext[i][0] = entries[i].op.srcReady0 ||
                                 tagMatch(entries[i].op.srcTag0, broadcast);
            srcReadyNext[i][1] = entries[i].op.srcReady1 ||
                                 tagMatch(entries[i].op.srcTag1, broadcast);
            ready[i] = entries[i].valid && srcReadyNext[i][0] && srcReadyNext[i][1];
        end
    end

    // An op dispatched during a broadcast must not miss it
    always_comb begin
        dispatchReady[0] = dispatchOp.srcReady0 ||
                           (dispatchValid && tagMatch(dispatchOp.srcTag0, broadcast));
        dispatchReady[1] = dispatchOp.srcReady1 ||
                           (dispatchValid && tagMatch(dispatchOp.srcTag1, broadcast));
    end

endmodule : WakeupLogic

// File: verilog/scheduler_cfg.svh
//**************************************************
// Scheduler sizing: queue depth, issue widths per
// pipe class, tag and op label widths
//**************************************************

`ifndef SCHEDULER_CFG_SVH
`define SCHEDULER_CFG_SVH

// Issue queue depth
`define SCHED_ENTRY_NUM 8
`define SCHED_ENTRY_PTR_WIDTH $clog2(`SCHED_ENTRY_NUM)

// Issue width per pipe class
`define SCHED_INT_WIDTH 2
`define SCHED_COMPLEX_WIDTH 1
`define SCHED_MEM_WIDTH 1
`define SCHED_ISSUE_WIDTH (`SCHED_INT_WIDTH + `SCHED_COMPLEX_WIDTH + `SCHED_MEM_WIDTH)

// First issue slot of each class
`define SCHED_COMPLEX_SLOT `SCHED_INT_WIDTH
`define SCHED_MEM_SLOT (`SCHED_INT_WIDTH + `SCHED_COMPLEX_WIDTH)

// Physical register tag and op label
`define SCHED_TAG_WIDTH 5
`define SCHED_OPID_WIDTH 8

`endif
